/* compile.f */
+incdir+design
design/bus_pkg.sv
design/clint_timer.sv
design/axi_lite_master.sv
design/bus_arbiter.sv
design/core_bus.sv
test/axi_lite_slave_model.sv
test/core_bus_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := core_bus_tb
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Verification passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* test/core_bus_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bus_macros.svh"

module core_bus_tb
    import bus_pkg::*;
();

    localparam int    seed_value  = 43407;
    localparam int    cycle_limit = 4000;   // about four times the full run
    localparam int    ext_words   = 12;
    localparam addr_t ext_base    = 32'h8000_0000;
    localparam addr_t err_base    = 32'hF000_0000;   // slave answers SLVERR here

    logic  clock;
    logic  reset;
    logic  fetch_valid, fetch_done, fetch_error;
    addr_t fetch_addr;
    data_t fetch_rdata;
    logic  data_valid, data_write, data_done, data_error;
    addr_t data_addr;
    data_t data_wdata, data_rdata;
    strb_t data_wstrb;
    logic  timer_interrupt;
    logic  m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
    logic  m_arvalid, m_arready, m_rvalid, m_rready;
    addr_t m_awaddr, m_araddr;
    data_t m_wdata, m_rdata;
    strb_t m_wstrb;
    resp_t m_bresp, m_rresp;

    integer seed = seed_value;
    int     cycles = 0;
    int     value_errors = 0;
    int     protocol_errors = 0;
    int     data_reqs = 0;
    int     fetch_reqs = 0;
    int     data_dones = 0;
    int     fetch_dones = 0;
    logic   clint_active = 1'b0;   // no AXI traffic while set
    logic   irq_hold = 1'b0;
    data_t  shadow [ext_words];

    core_bus UUT (.*);

    axi_lite_slave_model #(.seed_init(seed_value)) slave (
        .clock   (clock),
        .reset   (reset),
        .awvalid (m_awvalid),
        .awready (m_awready),
        .awaddr  (m_awaddr),
        .wvalid  (m_wvalid),
        .wready  (m_wready),
        .wdata   (m_wdata),
        .wstrb   (m_wstrb),
        .bvalid  (m_bvalid),
        .bready  (m_bready),
        .bresp   (m_bresp),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .araddr  (m_araddr),
        .rvalid  (m_rvalid),
        .rready  (m_rready),
        .rdata   (m_rdata),
        .rresp   (m_rresp)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (data_done) begin
            data_dones <= data_dones + 1;
        end
        if (fetch_done) begin
            fetch_dones <= fetch_dones + 1;
        end
        if (cycles >= cycle_limit) begin
            $display("error: no result after %0d cycles, a request never completed", cycles);
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("Verification failed");
            $finish;
        end
    end

    // --------------------
    // bus protocol checks
    aw_hold: assert property (@(posedge clock) disable iff (reset)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
        else begin
            protocol_errors++;
            $display("error at %0t: awvalid dropped or awaddr moved before awready", $time);
        end
    w_hold: assert property (@(posedge clock) disable iff (reset)
        m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wstrb))
        else begin
            protocol_errors++;
            $display("error at %0t: wvalid dropped or write data moved before wready", $time);
        end
    ar_hold: assert property (@(posedge clock) disable iff (reset)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
        else begin
            protocol_errors++;
            $display("error at %0t: arvalid dropped or araddr moved before arready", $time);
        end
    clint_quiet: assert property (@(posedge clock) disable iff (reset)
        clint_active |-> !(m_awvalid || m_wvalid || m_arvalid))
        else begin
            protocol_errors++;
            $display("error at %0t: a CLINT access raised an AXI valid", $time);
        end
    done_pulse: assert property (@(posedge clock) disable iff (reset)
        (data_done || fetch_done) |=> !(data_done || fetch_done))
        else begin
            protocol_errors++;
            $display("error at %0t: done held high for two cycles", $time);
        end
    done_one_port: assert property (@(posedge clock) disable iff (reset)
        !(data_done && fetch_done))
        else begin
            protocol_errors++;
            $display("error at %0t: done given to both ports at once", $time);
        end
    irq_stays: assert property (@(posedge clock) disable iff (reset)
        irq_hold |-> timer_interrupt)
        else begin
            protocol_errors++;
            $display("error at %0t: timer interrupt fell while mtimecmp was unchanged", $time);
        end

    function automatic data_t rand_word();
        int hi;
        int lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    function automatic data_t merge_expected(input data_t old_val, input data_t new_val,
                                             input strb_t strb);
        data_t mask;
        for (int i = 0; i < `BUS_STRB_W; i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return (new_val & mask) | (old_val & ~mask);
    endfunction

    task automatic check_value(input string what, input data_t got, input data_t expected);
        assert (got === expected) else begin
            value_errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic data_access(input logic write, input addr_t addr, input data_t wdata,
                               input strb_t wstrb, output data_t rdata, output logic error,
                               output int latency);
        int start;
        @(negedge clock);
        data_valid = 1'b1;
        data_write = write;
        data_addr  = addr;
        data_wdata = wdata;
        data_wstrb = wstrb;
        data_reqs++;
        start = cycles;
        do begin
            @(negedge clock);
        end while (!data_done);
        rdata      = data_rdata;
        error      = data_error;
        latency    = cycles - start;
        data_valid = 1'b0;
        @(negedge clock);   // idle gap after done
    endtask

    task automatic fetch_access(input addr_t addr, output data_t rdata, output logic error,
                                output int latency);
        int start;
        @(negedge clock);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        fetch_reqs++;
        start = cycles;
        do begin
            @(negedge clock);
        end while (!fetch_done);
        rdata       = fetch_rdata;
        error       = fetch_error;
        latency     = cycles - start;
        fetch_valid = 1'b0;
        @(negedge clock);
    endtask

    task automatic ext_write(input int idx, input data_t wdata, input strb_t wstrb);
        data_t rd;
        logic  err;
        int    lat;
        data_access(1'b1, ext_base + addr_t'(idx * 8), wdata, wstrb, rd, err, lat);
        shadow[idx] = merge_expected(shadow[idx], wdata, wstrb);
        check_value("external write error", data_t'(err), 64'd0);
    endtask

    task automatic ext_read(input int idx, input logic use_fetch);
        data_t rd;
        logic  err;
        int    lat;
        if (use_fetch) begin
            fetch_access(ext_base + addr_t'(idx * 8), rd, err, lat);
        end else begin
            data_access(1'b0, ext_base + addr_t'(idx * 8), '0, '0, rd, err, lat);
        end
        check_value("external read data", rd, shadow[idx]);
        check_value("external read error", data_t'(err), 64'd0);
    endtask

    task automatic clint_access(input logic write, input logic [15:0] ofs, input data_t wdata,
                                output data_t rdata, output logic error);
        int lat;
        data_access(write, `CLINT_BASE | {16'h0, ofs}, wdata, 8'hFF, rdata, error, lat);
        check_value("CLINT access cycles", data_t'(lat), 64'd3);
    endtask

    initial begin
        data_t rd;
        data_t rd2;
        data_t t0;
        data_t t1;
        logic  err;
        logic  err2;
        int    lat;
        int    lat2;
        int    r;
        int    wait_cycles;

        fetch_valid = 1'b0;
        fetch_addr  = '0;
        data_valid  = 1'b0;
        data_write  = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        data_wstrb  = '0;
        for (int i = 0; i < ext_words; i++) begin
            shadow[i] = '0;
        end
        reset = 1'b1;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        @(negedge clock);
        check_value("done, interrupt and AXI handshake lines after reset",
                    data_t'({fetch_done, data_done, timer_interrupt, m_awvalid, m_wvalid,
                             m_arvalid, m_bready, m_rready}), 64'd0);

        // --------------------
        // external memory with full words then random strobes
        for (int i = 0; i < ext_words; i++) begin
            ext_write(i, rand_word(), 8'hFF);
        end
        for (int i = 0; i < ext_words; i++) begin
            r = $random(seed);
            ext_write(i, rand_word(), r[7:0]);
        end
        for (int i = 0; i < ext_words; i++) begin
            ext_read(i, i % 2 == 0);   // alternate fetch and data reads
        end

        // --------------------
        // CLINT registers and timer
        clint_active = 1'b1;
        clint_access(1'b1, `CLINT_MTIMECMP_OFS, 64'hFFFF_0000_1234_5678, rd, err);
        clint_access(1'b0, `CLINT_MTIMECMP_OFS, '0, rd, err);
        check_value("mtimecmp readback", rd, 64'hFFFF_0000_1234_5678);
        clint_access(1'b0, `CLINT_MTIME_OFS, '0, t0, err);
        clint_access(1'b0, `CLINT_MTIME_OFS, '0, t1, err);
        assert (t1 > t0) else begin
            value_errors++;
            $display("FAIL %0t: mtime read %0d after %0d", $time, t1, t0);
        end
        clint_access(1'b1, `CLINT_MTIMECMP_OFS, t1 + 64'd50, rd, err);
        wait_cycles = 0;
        while (!timer_interrupt && wait_cycles < 60) begin
            @(negedge clock);
            wait_cycles++;
        end
        check_value("timer interrupt after compare", data_t'(timer_interrupt), 64'd1);
        irq_hold = 1'b1;
        repeat (20) @(negedge clock);
        irq_hold = 1'b0;
        clint_access(1'b1, `CLINT_MTIMECMP_OFS, '1, rd, err);
        check_value("timer interrupt after mtimecmp reset", data_t'(timer_interrupt), 64'd0);
        clint_access(1'b0, 16'h0100, '0, rd, err);
        check_value("unmapped CLINT offset error", data_t'(err), 64'd1);
        clint_active = 1'b0;

        // --------------------
        // tie between the ports
        fork
            data_access(1'b0, ext_base, '0, '0, rd, err, lat);
            fetch_access(ext_base + 32'd8, rd2, err2, lat2);
        join
        check_value("data read in tie", rd, shadow[0]);
        check_value("fetch read in tie", rd2, shadow[1]);
        check_value("errors in tie", data_t'({err, err2}), 64'd0);
        assert (lat < lat2) else begin
            value_errors++;
            $display("FAIL %0t: data done after %0d cycles, fetch after %0d", $time, lat, lat2);
        end

        // --------------------
        // slave errors then a clean access
        data_access(1'b0, err_base + 32'h40, '0, '0, rd, err, lat);
        check_value("read error response", data_t'(err), 64'd1);
        data_access(1'b1, err_base + 32'h80, rand_word(), 8'hFF, rd, err, lat);
        check_value("write error response", data_t'(err), 64'd1);
        ext_read(2, 1'b0);

        check_value("data done pulses", data_t'(data_dones), data_t'(data_reqs));
        check_value("fetch done pulses", data_t'(fetch_dones), data_t'(fetch_reqs));
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/axi_lite_slave_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bus_macros.svh"

module axi_lite_slave_model
    import bus_pkg::*;
#(
    parameter int seed_init = 1
) (
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  awvalid,
    output logic       awready,
    input  wire addr_t awaddr,
    input  wire logic  wvalid,
    output logic       wready,
    input  wire data_t wdata,
    input  wire strb_t wstrb,
    output logic       bvalid,
    input  wire logic  bready,
    output resp_t      bresp,
    input  wire logic  arvalid,
    output logic       arready,
    input  wire addr_t araddr,
    output logic       rvalid,
    input  wire logic  rready,
    output data_t      rdata,
    output resp_t      rresp
);

    localparam int depth = 256;

    data_t      mem [depth];   // word index is addr[10:3]
    integer     seed = seed_init;
    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic [1:0] ar_wait;
    logic       aw_taken;
    logic       w_taken;
    addr_t      waddr_q;
    data_t      wdata_q;
    strb_t      wstrb_q;

    function automatic logic [1:0] pick_delay();
        integer r;
        r = $random(seed);
        return r[1:0];
    endfunction

    function automatic logic in_error_window(input addr_t addr);
        return addr[31:28] == 4'hF;
    endfunction

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            arready  <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            bresp    <= `AXI_RESP_OKAY;
            rresp    <= `AXI_RESP_OKAY;
            rdata    <= '0;
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
            aw_wait  <= 2'd0;
            w_wait   <= 2'd0;
            ar_wait  <= 2'd0;
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // --------------------
            // aw and w, each with its own ready delay
            if (awvalid && awready) begin
                awready  <= 1'b0;
                aw_taken <= 1'b1;
                waddr_q  <= awaddr;
                aw_wait  <= pick_delay();
            end else if (awvalid && !aw_taken) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                w_taken <= 1'b1;
                wdata_q <= wdata;
                wstrb_q <= wstrb;
                w_wait  <= pick_delay();
            end else if (wvalid && !w_taken) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end
            if (aw_taken && w_taken && !bvalid) begin
                bvalid <= 1'b1;
                if (in_error_window(waddr_q)) begin
                    bresp <= `AXI_RESP_SLVERR;   // error window is never written
                end else begin
                    bresp <= `AXI_RESP_OKAY;
                    for (int i = 0; i < `BUS_STRB_W; i++) begin
                        if (wstrb_q[i]) begin
                            mem[waddr_q[10:3]][8*i +: 8] <= wdata_q[8*i +: 8];
                        end
                    end
                end
            end
            if (bvalid && bready) begin
                bvalid   <= 1'b0;
                aw_taken <= 1'b0;
                w_taken  <= 1'b0;
            end

            // --------------------
            // read path
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_wait <= pick_delay();
                rvalid  <= 1'b1;
                rresp   <= in_error_window(araddr) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
                rdata   <= in_error_window(araddr) ? '0 : mem[araddr[10:3]];
            end else if (arvalid && !rvalid) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/core_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module core_bus
    import bus_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  fetch_valid,
    input  wire addr_t fetch_addr,
    output logic       fetch_done,
    output data_t      fetch_rdata,
    output logic       fetch_error,
    input  wire logic  data_valid,
    input  wire logic  data_write,
    input  wire addr_t data_addr,
    input  wire data_t data_wdata,
    input  wire strb_t data_wstrb,
    output logic       data_done,
    output data_t      data_rdata,
    output logic       data_error,
    output logic       timer_interrupt,
    output logic       m_awvalid,
    input  wire logic  m_awready,
    output addr_t      m_awaddr,
    output logic       m_wvalid,
    input  wire logic  m_wready,
    output data_t      m_wdata,
    output strb_t      m_wstrb,
    input  wire logic  m_bvalid,
    output logic       m_bready,
    input  wire resp_t m_bresp,
    output logic       m_arvalid,
    input  wire logic  m_arready,
    output addr_t      m_araddr,
    input  wire logic  m_rvalid,
    output logic       m_rready,
    input  wire data_t m_rdata,
    input  wire resp_t m_rresp
);

    // --------------------
    // shared target request, one access in flight
    logic  clint_req;
    logic  axi_req;
    logic  req_write;
    addr_t req_addr;
    data_t req_wdata;
    strb_t req_wstrb;
    logic  clint_resp_valid;
    data_t clint_rdata;
    resp_t clint_resp;
    logic  axi_resp_valid;
    data_t axi_rdata;
    resp_t axi_resp;

    bus_arbiter u_arbiter (.*);   // port names match the top level

    clint_timer u_clint (
        .clock           (clock),
        .reset           (reset),
        .req             (clint_req),
        .write           (req_write),
        .addr            (req_addr),
        .wdata           (req_wdata),
        .wstrb           (req_wstrb),
        .resp_valid      (clint_resp_valid),
        .rdata           (clint_rdata),
        .resp            (clint_resp),
        .timer_interrupt (timer_interrupt)
    );

    axi_lite_master u_master (
        .clock      (clock),
        .reset      (reset),
        .req        (axi_req),
        .write      (req_write),
        .addr       (req_addr),
        .wdata      (req_wdata),
        .wstrb      (req_wstrb),
        .resp_valid (axi_resp_valid),
        .rdata      (axi_rdata),
        .resp       (axi_resp),
        .awvalid    (m_awvalid),
        .awready    (m_awready),
        .awaddr     (m_awaddr),
        .wvalid     (m_wvalid),
        .wready     (m_wready),
        .wdata_out  (m_wdata),
        .wstrb_out  (m_wstrb),
        .bvalid     (m_bvalid),
        .bready     (m_bready),
        .bresp      (m_bresp),
        .arvalid    (m_arvalid),
        .arready    (m_arready),
        .araddr     (m_araddr),
        .rvalid     (m_rvalid),
        .rready     (m_rready),
        .rdata_in   (m_rdata),
        .rresp      (m_rresp)
    );

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bus_macros.svh"

module bus_arbiter
    import bus_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  fetch_valid,
    input  wire addr_t fetch_addr,
    output logic       fetch_done,
    output data_t      fetch_rdata,
    output logic       fetch_error,
    input  wire logic  data_valid,
    input  wire logic  data_write,
    input  wire addr_t data_addr,
    input  wire data_t data_wdata,
    input  wire strb_t data_wstrb,
    output logic       data_done,
    output data_t      data_rdata,
    output logic       data_error,
    output logic       clint_req,
    output logic       axi_req,
    output logic       req_write,
    output addr_t      req_addr,
    output data_t      req_wdata,
    output strb_t      req_wstrb,
    input  wire logic  clint_resp_valid,
    input  wire data_t clint_rdata,
    input  wire resp_t clint_resp,
    input  wire logic  axi_resp_valid,
    input  wire data_t axi_rdata,
    input  wire resp_t axi_resp
);

    typedef enum logic [1:0] {
        idle,
        wait_clint,
        wait_axi,
        done
    } state_t;

    state_t state;
    logic   grant_data;     // data port owns the current access
    logic   pick_valid;
    addr_t  pick_addr;
    logic   pick_clint;
    logic   resp_valid;
    data_t  resp_rdata;
    resp_t  resp_code;
    data_t  rdata_q;
    logic   error_q;

    // --------------------
    // request selection and target decode

    assign pick_valid = data_valid || fetch_valid;
    assign pick_addr  = data_valid ? data_addr : fetch_addr;   // data port wins a tie
    assign pick_clint = (pick_addr & `CLINT_MASK) == `CLINT_BASE;

    // only the target that was started may answer
    assign resp_valid = (state == wait_clint) ? clint_resp_valid
                                              : (state == wait_axi) && axi_resp_valid;
    assign resp_rdata = (state == wait_clint) ? clint_rdata : axi_rdata;
    assign resp_code  = (state == wait_clint) ? clint_resp : axi_resp;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= idle;
            grant_data <= 1'b0;
            req_write  <= 1'b0;
            clint_req  <= 1'b0;
            axi_req    <= 1'b0;
        end else begin
            clint_req <= 1'b0;
            axi_req   <= 1'b0;
            case (state)
                idle: begin
                    if (pick_valid) begin
                        grant_data <= data_valid;
                        req_write  <= data_valid && data_write;   // fetch is always a read
                        clint_req  <= pick_clint;
                        axi_req    <= !pick_clint;
                        state      <= pick_clint ? wait_clint : wait_axi;
                    end
                end
                wait_clint, wait_axi: begin
                    if (resp_valid) begin
                        state <= done;
                    end
                end
                done: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // fields stay put until the target answers
    always_ff @(posedge clock) begin
        if (state == idle && pick_valid) begin
            req_addr  <= pick_addr;
            req_wdata <= data_valid ? data_wdata : '0;
            req_wstrb <= data_valid ? data_wstrb : '0;
        end
        if (resp_valid) begin
            rdata_q <= resp_rdata;
            error_q <= resp_code == `AXI_RESP_SLVERR;
        end
    end

    // --------------------
    // result back to the granted requester

    assign fetch_done  = (state == done) && !grant_data;
    assign data_done   = (state == done) && grant_data;
    assign fetch_rdata = rdata_q;
    assign data_rdata  = rdata_q;
    assign fetch_error = error_q;
    assign data_error  = error_q;

endmodule

`default_nettype wire

/* design/axi_lite_master.sv */
`timescale 1ns/10ps
`default_nettype none

module axi_lite_master
    import bus_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  req,
    input  wire logic  write,
    input  wire addr_t addr,
    input  wire data_t wdata,
    input  wire strb_t wstrb,
    output logic       resp_valid,
    output data_t      rdata,
    output resp_t      resp,
    output logic       awvalid,
    input  wire logic  awready,
    output addr_t      awaddr,
    output logic       wvalid,
    input  wire logic  wready,
    output data_t      wdata_out,
    output strb_t      wstrb_out,
    input  wire logic  bvalid,
    output logic       bready,
    input  wire resp_t bresp,
    output logic       arvalid,
    input  wire logic  arready,
    output addr_t      araddr,
    input  wire logic  rvalid,
    output logic       rready,
    input  wire data_t rdata_in,
    input  wire resp_t rresp
);

    typedef enum logic [2:0] {
        idle,
        write_addr_data,
        write_resp,
        read_addr,
        read_data
    } state_t;

    state_t state;
    logic   aw_ok;   // aw accepted now or earlier
    logic   w_ok;

    // arbiter holds the request fields until resp_valid
    assign awaddr    = addr;
    assign araddr    = addr;
    assign wdata_out = wdata;
    assign wstrb_out = wstrb;

    assign aw_ok = !awvalid || awready;
    assign w_ok  = !wvalid || wready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= idle;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            bready     <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                idle: begin
                    if (req && write) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        bready  <= 1'b1;
                        state   <= write_addr_data;
                    end else if (req) begin
                        arvalid <= 1'b1;
                        rready  <= 1'b1;
                        state   <= read_addr;
                    end
                end
                write_addr_data: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_ok && w_ok) begin
                        state <= write_resp;
                    end
                end
                write_resp: begin
                    if (bvalid) begin
                        bready     <= 1'b0;
                        resp_valid <= 1'b1;
                        state      <= idle;
                    end
                end
                read_addr: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= read_data;
                    end
                end
                read_data: begin
                    if (rvalid) begin
                        rready     <= 1'b0;
                        resp_valid <= 1'b1;
                        state      <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // --------------------
    // response capture
    always_ff @(posedge clock) begin
        if (state == write_resp && bvalid) begin
            rdata <= '0;
            resp  <= bresp;
        end else if (state == read_data && rvalid) begin
            rdata <= rdata_in;
            resp  <= rresp;
        end
    end

endmodule

`default_nettype wire

/* design/clint_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bus_macros.svh"

module clint_timer
    import bus_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  req,
    input  wire logic  write,
    input  wire addr_t addr,
    input  wire data_t wdata,
    input  wire strb_t wstrb,
    output logic       resp_valid,
    output data_t      rdata,
    output resp_t      resp,
    output logic       timer_interrupt
);

    data_t       mtime;
    data_t       mtimecmp;
    logic [15:0] offset;
    logic        hit_mtime;
    logic        hit_cmp;

    function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                          input strb_t strb);
        data_t result;
        result = old_val;
        for (int i = 0; i < `BUS_STRB_W; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign offset    = addr[15:0];   // window already decoded upstream
    assign hit_mtime = offset == `CLINT_MTIME_OFS;
    assign hit_cmp   = offset == `CLINT_MTIMECMP_OFS;

    // --------------------
    // timer registers

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mtime           <= '0;
            mtimecmp        <= '1;
            timer_interrupt <= 1'b0;
            resp_valid      <= 1'b0;
        end else begin
            resp_valid      <= req;   // fixed one-cycle answer
            timer_interrupt <= mtime >= mtimecmp;
            if (req && write && hit_mtime) begin
                mtime <= merge_bytes(mtime + 64'd1, wdata, wstrb);   // unwritten lanes keep counting
            end else begin
                mtime <= mtime + 64'd1;
            end
            if (req && write && hit_cmp) begin
                mtimecmp <= merge_bytes(mtimecmp, wdata, wstrb);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req) begin
            resp <= (hit_mtime || hit_cmp) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
            if (write || !(hit_mtime || hit_cmp)) begin
                rdata <= '0;
            end else begin
                rdata <= hit_mtime ? mtime : mtimecmp;
            end
        end
    end

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none

`include "bus_macros.svh"

package bus_pkg;

    // --------------------
    // payload types shared by the arbiter and both targets

    typedef logic [`BUS_ADDR_W-1:0] addr_t;
    typedef logic [`BUS_DATA_W-1:0] data_t;   // one full beat
    typedef logic [`BUS_STRB_W-1:0] strb_t;   // byte lane enables
    typedef logic [1:0]             resp_t;   // AXI resp encoding

endpackage

`default_nettype wire

/* design/bus_macros.svh */
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// --------------------
// bus widths
`define BUS_ADDR_W          32
`define BUS_DATA_W          64
`define BUS_STRB_W          8                // one strobe per data byte

// --------------------
// address map
`define CLINT_BASE          32'h0200_0000
`define CLINT_MASK          32'hFFFF_0000    // 64 KiB window
`define CLINT_MTIMECMP_OFS  16'h4000
`define CLINT_MTIME_OFS     16'hBFF8

// --------------------
// AXI response codes
`define AXI_RESP_OKAY       2'b00
`define AXI_RESP_SLVERR     2'b10

`endif
